//--- verilog.f
img_pkg.sv
img_sram.sv
haar_unit.sv
img_ctrl.sv
img_core.sv
img_core_checker.sv
tb_img_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the image engine testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_img_core
./obj_dir/Vtb_img_core 2>&1 | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
	echo "FAIL: simulation ended early"
	exit 1
fi
echo "PASS"

//--- tb_img_core.sv
`timescale 1ns/10ps

module tb_img_core
	import img_pkg::*;
();

	localparam int CLK_HALF    = 4;
	localparam int NUM_CMDS    = 100;
	localparam int CYCLE_LIMIT = 3 * (2 * MEM_DEPTH + 200 * NUM_CMDS);

	logic             i_clk;
	logic             i_rst_n;
	logic             i_op_valid;
	logic [3:0]       i_op_mode;
	logic             o_op_ready;
	logic             i_in_valid;
	logic [PIX_W-1:0] i_in_data;
	logic             o_in_ready;
	logic             o_out_valid;
	logic [OUT_W-1:0] o_out_data;

	// reference model of the image, window origin and depth
	logic [PIX_W-1:0] img [0:MEM_DEPTH-1];
	int               model_x;
	int               model_y;
	int               model_depth;

	logic [15:0]      lfsr;
	logic [OUT_W-1:0] out_q [$];
	logic [OUT_W-1:0] exp_q [$];
	int               cycle_cnt = 0;
	int               accept_cycle;
	int               first_out_cycle;
	int               err_cnt;
	int               test_err_base;
	int               tests_run;
	int               tests_failed;

	img_core u_dut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #CLK_HALF i_clk = ~i_clk;
	end

	// output monitor collects one queue per command
	always @(posedge i_clk) begin
		if (o_out_valid) begin
			if (out_q.size() == 0) begin
				first_out_cycle = cycle_cnt;
			end
			out_q.push_back(o_out_data);
		end
		cycle_cnt <= cycle_cnt + 1;
	end

	always @(posedge i_clk) begin
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// 16-bit fibonacci lfsr for random bits with taps 16 14 13 11
	// ------------------------------------------------------------
	function automatic int rand_bits(input int n);
		int   v;
		logic fb;
		v = 0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	function automatic int pix_at(input int ch, input int x, input int y);
		return int'(img[ch * IMG_W * IMG_W + y * IMG_W + x]);
	endfunction

	// clamped origin and saturating depth
	task automatic update_model(input logic [3:0] op);
		case (op)
			OP_RIGHT:    if (model_x < ORIGIN_MAX) model_x++;
			OP_LEFT:     if (model_x > 0) model_x--;
			OP_UP:       if (model_y > 0) model_y--;
			OP_DOWN:     if (model_y < ORIGIN_MAX) model_y++;
			OP_DEPTH_DN: if (model_depth > DEPTH_MIN) model_depth = model_depth / 2;
			OP_DEPTH_UP: if (model_depth < CHAN_MAX) model_depth = model_depth * 2;
			default: ;
		endcase
	endtask

	task automatic expect_display();
		exp_q.delete();
		for (int ch = 0; ch < model_depth; ch++) begin
			for (int k = 0; k < 4; k++) begin
				exp_q.push_back(OUT_W'(pix_at(ch, model_x + k % 2, model_y + k / 2)));
			end
		end
	endtask

	task automatic expect_haar();
		int a, b, c, d, s;
		exp_q.delete();
		for (int ch = 0; ch < HAAR_CHANS; ch++) begin
			a = pix_at(ch, model_x, model_y);
			b = pix_at(ch, model_x + 1, model_y);
			c = pix_at(ch, model_x, model_y + 1);
			d = pix_at(ch, model_x + 1, model_y + 1);
			for (int k = 0; k < 4; k++) begin
				case (k)
					0:       s = a + b + c + d;
					1:       s = a - b + c - d;
					2:       s = a + b - c - d;
					default: s = a - b - c + d;
				endcase
				// halve, then add back the dropped bit
				exp_q.push_back(OUT_W'((s >>> 1) + (s & 1)));
			end
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic feed_image();
		int   n;
		logic gap_prev;
		n        = 0;
		gap_prev = 1'b0;
		while (n < MEM_DEPTH) begin
			i_op_valid = 1'b1;
			i_op_mode  = 4'(rand_bits(4));
			// one-cycle gaps in about one cycle of four
			i_in_valid = gap_prev ? 1'b1 : (rand_bits(2) != 0);
			i_in_data  = PIX_W'(rand_bits(PIX_W));
			gap_prev   = !i_in_valid;
			@(posedge i_clk);
			assert (o_in_ready) else begin
				$display("error: o_in_ready is %h during load, expected %h", o_in_ready, 1'b1);
				err_cnt++;
			end
			if (i_in_valid) begin
				img[n] = i_in_data;
				n++;
			end
			@(negedge i_clk);
		end
		i_in_valid = 1'b0;
		assert (!o_in_ready) else begin
			$display("error: o_in_ready is %h after load, expected %h", o_in_ready, 1'b0);
			err_cnt++;
		end
	endtask

	// issue one opcode, then keep random opcodes on the bus until idle
	task automatic run_cmd(input logic [3:0] op);
		@(negedge i_clk);
		while (!o_op_ready) @(negedge i_clk);
		out_q.delete();
		i_op_valid = 1'b1;
		i_op_mode  = op;
		@(posedge i_clk);
		accept_cycle = cycle_cnt;
		@(negedge i_clk);
		if (op == OP_LOAD) begin
			feed_image();
		end
		while (!o_op_ready) begin
			i_op_valid = 1'b1;
			i_op_mode  = 4'(rand_bits(4));
			@(negedge i_clk);
		end
		i_op_valid = 1'b0;
	endtask

	task automatic compare_outputs(input string what);
		assert (out_q.size() == exp_q.size()) else begin
			$display("%s returned %0d outputs where %0d were expected",
				what, out_q.size(), exp_q.size());
			err_cnt++;
		end
		for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
			assert (out_q[i] == exp_q[i]) else begin
				$display("error: o_out_data %s output %0d is %h, expected %h",
					what, i, out_q[i], exp_q[i]);
				err_cnt++;
			end
		end
	endtask

	task automatic do_adjust(input logic [3:0] op);
		run_cmd(op);
		update_model(op);
		assert (out_q.size() == 0) else begin
			$display("opcode %0d produced %0d outputs, none expected", op, out_q.size());
			err_cnt++;
		end
		assert (cycle_cnt - accept_cycle <= 4) else begin
			$display("opcode %0d took %0d cycles to return to idle", op, cycle_cnt - accept_cycle);
			err_cnt++;
		end
	endtask

	task automatic do_display();
		run_cmd(OP_DISPLAY);
		expect_display();
		compare_outputs("display");
	endtask

	task automatic do_haar();
		run_cmd(OP_HAAR);
		expect_haar();
		compare_outputs("haar");
		if (out_q.size() > 0) begin
			assert (first_out_cycle - accept_cycle == 6) else begin
				$display("haar gave its first output %0d cycles after the opcode, not 6",
					first_out_cycle - accept_cycle);
				err_cnt++;
			end
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt == test_err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_cnt - test_err_base);
		end
		test_err_base = err_cnt;
	endtask

	initial begin
		int n, dir, len;
		i_rst_n       = 1'b0;
		i_op_valid    = 1'b0;
		i_op_mode     = 4'd0;
		i_in_valid    = 1'b0;
		i_in_data     = '0;
		lfsr          = 16'd20;
		model_x       = 0;
		model_y       = 0;
		model_depth   = CHAN_MAX;
		err_cnt       = 0;
		test_err_base = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;

		assert (o_op_ready && !o_in_ready && !o_out_valid) else begin
			$display("error: after reset o_op_ready %h o_in_ready %h o_out_valid %h, expected 1 0 0",
				o_op_ready, o_in_ready, o_out_valid);
			err_cnt++;
		end

		run_cmd(OP_LOAD);
		do_display();
		end_test("load and display");

		// bursts in one direction drive the window into the edges
		n = 0;
		while (n < 30) begin
			dir = 1 + rand_bits(2);
			len = 3 + rand_bits(3);
			for (int k = 0; k < len && n < 30; k++) begin
				do_adjust(4'(dir));
				n++;
			end
			do_display();
		end
		end_test("shift and clamp");

		for (int k = 0; k < 4; k++) begin
			do_adjust(OP_DEPTH_DN);
		end
		do_display();
		do_adjust(OP_DEPTH_UP);
		do_display();
		for (int k = 0; k < 4; k++) begin
			do_adjust(OP_DEPTH_UP);
		end
		do_display();
		end_test("depth saturation");

		for (int r = 0; r < 5; r++) begin
			for (int s = 0; s < 3; s++) begin
				do_adjust(4'(1 + rand_bits(2)));
			end
			do_haar();
		end
		end_test("haar");

		do_adjust(OP_DEPTH_DN);
		do_adjust(OP_CONV);
		do_adjust(OP_MEDIAN);
		do_adjust(4'd15);
		do_display();
		end_test("dropped opcodes");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- img_core_checker.sv
`timescale 1ns/10ps

module img_core_checker
	import img_pkg::*;
(
	input logic             i_clk,
	input logic             i_rst_n,
	input logic             i_op_valid,
	input logic             o_op_ready,
	input logic             o_in_ready,
	input logic             o_out_valid,
	input logic [OUT_W-1:0] o_out_data
);

	// outputs only come while a command is running
	a_out_vs_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_out_valid && o_op_ready))
		else $error("o_out_valid high together with o_op_ready");

	a_load_vs_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_in_ready && o_op_ready))
		else $error("o_in_ready high together with o_op_ready");

	// idle bus carries zero
	a_data_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!o_out_valid |-> o_out_data == '0)
		else $error("o_out_data nonzero while o_out_valid is low");

	a_accept_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_op_valid && o_op_ready) |=> !o_op_ready)
		else $error("o_op_ready still high in the cycle after an accepted opcode");

endmodule

bind img_core img_core_checker u_checker (.*);

//--- img_core.sv
`timescale 1ns/10ps

module img_core
	import img_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_op_valid,
	input  logic [3:0]       i_op_mode,
	output logic             o_op_ready,
	input  logic             i_in_valid,
	input  logic [PIX_W-1:0] i_in_data,
	output logic             o_in_ready,
	output logic             o_out_valid,
	output logic [OUT_W-1:0] o_out_data
);

	op_e              op_mode;
	mem_req_t         mem_req;
	logic [PIX_W-1:0] mem_rdata;
	pix_t             haar_pix;
	coef_t            haar_coef;
	logic             haar_busy;

	// raw codes outside the enum fall to the no-op path in the FSM
	assign op_mode = op_e'(i_op_mode);

	img_ctrl u_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.i_rdata     (mem_rdata),
		.i_coef      (haar_coef),
		.i_haar_busy (haar_busy),
		.o_op_ready  (o_op_ready),
		.o_in_ready  (o_in_ready),
		.o_req       (mem_req),
		.o_pix       (haar_pix),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	img_sram u_sram (
		.i_clk   (i_clk),
		.i_req   (mem_req),
		.o_rdata (mem_rdata)
	);

	haar_unit u_haar (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_pix   (haar_pix),
		.o_coef  (haar_coef),
		.o_busy  (haar_busy)
	);

endmodule

//--- img_ctrl.sv
`timescale 1ns/10ps

module img_ctrl
	import img_pkg::*;
(
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_op_valid,
	input  op_e              i_op_mode,
	input  logic             i_in_valid,
	input  logic [PIX_W-1:0] i_in_data,
	input  logic [PIX_W-1:0] i_rdata,
	input  coef_t            i_coef,
	input  logic             i_haar_busy,
	output logic             o_op_ready,
	output logic             o_in_ready,
	output mem_req_t         o_req,
	output pix_t             o_pix,
	output logic             o_out_valid,
	output logic [OUT_W-1:0] o_out_data
);

	state_e state, state_nxt;
	op_e    op_r;

	logic [ADDR_W-1:0]  load_cnt;
	logic [COORD_W-1:0] org_x, org_y;
	logic [CHAN_W:0]    depth;

	// read counter, low two bits pick the window pixel, the rest the channel
	logic [CHAN_W+1:0]  rd_cnt;
	logic [CHAN_W+1:0]  rd_last;
	logic [COORD_W-1:0] rd_x, rd_y;
	logic [CHAN_W-1:0]  rd_chan;
	logic               rd_active;
	logic               rd_done;
	logic               rd_vld_d;

	// ------------------------------------------------------------
	// command FSM
	// ------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (i_op_valid) begin
					case (i_op_mode)
						OP_LOAD:    state_nxt = ST_LOAD;
						OP_DISPLAY: state_nxt = ST_DISPLAY;
						OP_HAAR:    state_nxt = ST_HAAR;
						default:    state_nxt = ST_ADJUST;
					endcase
				end
			end
			ST_LOAD: begin
				if (i_in_valid && load_cnt == ADDR_W'(MEM_DEPTH - 1)) begin
					state_nxt = ST_IDLE;
				end
			end
			ST_DISPLAY: begin
				// last output goes out in the cycle after the last read
				if (rd_done) begin
					state_nxt = ST_IDLE;
				end
			end
			ST_HAAR: begin
				if (rd_done && !i_haar_busy) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	assign rd_active = (state == ST_DISPLAY || state == ST_HAAR) && !rd_done;
	assign rd_last   = (state == ST_HAAR) ? (CHAN_W+2)'(HAAR_CHANS * 4 - 1) :
		(CHAN_W+2)'({depth, 2'b00} - 1'b1);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= ST_IDLE;
			op_r     <= OP_LOAD;
			load_cnt <= '0;
			org_x    <= '0;
			org_y    <= '0;
			depth    <= (CHAN_W+1)'(CHAN_MAX);
			rd_cnt   <= '0;
			rd_done  <= 1'b0;
			rd_vld_d <= 1'b0;
		end else begin
			state    <= state_nxt;
			rd_vld_d <= rd_active;
			if (state == ST_IDLE && i_op_valid) begin
				op_r <= i_op_mode;
			end
			// counter wraps to 0 after the last byte, ready for the next load
			if (state == ST_LOAD && i_in_valid) begin
				load_cnt <= load_cnt + 1'b1;
			end
			if (state == ST_IDLE) begin
				rd_cnt  <= '0;
				rd_done <= 1'b0;
			end else if (rd_active) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == rd_last) begin
					rd_done <= 1'b1;
				end
			end
			if (state == ST_ADJUST) begin
				case (op_r)
					OP_RIGHT:    if (org_x < COORD_W'(ORIGIN_MAX)) org_x <= org_x + 1'b1;
					OP_LEFT:     if (org_x != '0) org_x <= org_x - 1'b1;
					OP_UP:       if (org_y != '0) org_y <= org_y - 1'b1;
					OP_DOWN:     if (org_y < COORD_W'(ORIGIN_MAX)) org_y <= org_y + 1'b1;
					OP_DEPTH_DN: if (depth > (CHAN_W+1)'(DEPTH_MIN)) depth <= depth >> 1;
					OP_DEPTH_UP: if (depth < (CHAN_W+1)'(CHAN_MAX)) depth <= depth << 1;
					// convolution, median and unknown codes change nothing
					default: ;
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// memory addressing
	// ------------------------------------------------------------
	assign rd_x    = org_x + COORD_W'(rd_cnt[0]);
	assign rd_y    = org_y + COORD_W'(rd_cnt[1]);
	assign rd_chan = rd_cnt[CHAN_W+1:2];

	always_comb begin
		o_req = '0;
		if (state == ST_LOAD) begin
			o_req.en    = i_in_valid;
			o_req.we    = 1'b1;
			o_req.addr  = load_cnt;
			o_req.wdata = i_in_data;
		end else if (rd_active) begin
			o_req.en   = 1'b1;
			o_req.addr = {rd_chan, rd_y, rd_x};
		end
	end

	// ------------------------------------------------------------
	// output driver
	// ------------------------------------------------------------
	assign o_op_ready = (state == ST_IDLE);
	assign o_in_ready = (state == ST_LOAD);

	assign o_pix.valid = rd_vld_d && (state == ST_HAAR);
	assign o_pix.data  = i_rdata;

	always_comb begin
		o_out_valid = 1'b0;
		o_out_data  = '0;
		if (state == ST_DISPLAY && rd_vld_d) begin
			o_out_valid = 1'b1;
			o_out_data  = {{(OUT_W-PIX_W){1'b0}}, i_rdata};
		end else if (state == ST_HAAR && i_coef.valid) begin
			o_out_valid = 1'b1;
			o_out_data  = i_coef.data;
		end
	end

endmodule

//--- haar_unit.sv
`timescale 1ns/10ps

module haar_unit
	import img_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  pix_t  i_pix,
	output coef_t o_coef,
	output logic  o_busy
);

	// first three pixels of a window wait here, the fourth goes straight to hold
	logic [PIX_W-1:0] fill_buf [0:2];
	logic [PIX_W-1:0] hold_buf [0:3];
	logic [1:0]       pix_cnt;
	logic [1:0]       emit_cnt;
	logic             hold_vld;

	logic signed [OUT_W-1:0] a, b, c, d;
	logic signed [OUT_W-1:0] sum;
	logic signed [OUT_W-1:0] half;

	// ------------------------------------------------------------
	// counters
	// ------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pix_cnt  <= 2'd0;
			emit_cnt <= 2'd0;
			hold_vld <= 1'b0;
		end else begin
			if (i_pix.valid) begin
				pix_cnt <= pix_cnt + 2'd1;
			end
			if (i_pix.valid && pix_cnt == 2'd3) begin
				// new window lines up with the last emit of the previous one
				hold_vld <= 1'b1;
				emit_cnt <= 2'd0;
			end else if (hold_vld) begin
				emit_cnt <= emit_cnt + 2'd1;
				if (emit_cnt == 2'd3) begin
					hold_vld <= 1'b0;
				end
			end
		end
	end

	// pixel buffers
	always_ff @(posedge i_clk) begin
		if (i_pix.valid) begin
			case (pix_cnt)
				2'd0: fill_buf[0] <= i_pix.data;
				2'd1: fill_buf[1] <= i_pix.data;
				2'd2: fill_buf[2] <= i_pix.data;
				default: begin
					hold_buf[0] <= fill_buf[0];
					hold_buf[1] <= fill_buf[1];
					hold_buf[2] <= fill_buf[2];
					hold_buf[3] <= i_pix.data;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// coefficient, one per cycle in order LL, LH, HL, HH
	// ------------------------------------------------------------
	assign a = {{(OUT_W-PIX_W){1'b0}}, hold_buf[0]};
	assign b = {{(OUT_W-PIX_W){1'b0}}, hold_buf[1]};
	assign c = {{(OUT_W-PIX_W){1'b0}}, hold_buf[2]};
	assign d = {{(OUT_W-PIX_W){1'b0}}, hold_buf[3]};

	always_comb begin
		case (emit_cnt)
			2'd0:    sum = a + b + c + d;
			2'd1:    sum = a - b + c - d;
			2'd2:    sum = a + b - c - d;
			default: sum = a - b - c + d;
		endcase
	end

	// halve and round half up
	assign half = sum >>> 1;

	assign o_coef.valid = hold_vld;
	assign o_coef.data  = half + {{(OUT_W-1){1'b0}}, sum[0]};
	assign o_busy       = (pix_cnt != 2'd0) || hold_vld;

endmodule

//--- img_sram.sv
`timescale 1ns/10ps

module img_sram
	import img_pkg::*;
(
	input  logic             i_clk,
	input  mem_req_t         i_req,
	output logic [PIX_W-1:0] o_rdata
);

	// one byte per pixel, channel-major
	logic [PIX_W-1:0] mem [0:MEM_DEPTH-1];

	// single port, a write and a read never share a cycle
	always_ff @(posedge i_clk) begin
		if (i_req.en) begin
			if (i_req.we) begin
				mem[i_req.addr] <= i_req.wdata;
			end else begin
				// read data lands one cycle after the request
				o_rdata <= mem[i_req.addr];
			end
		end
	end

endmodule

//--- img_pkg.sv
package img_pkg;

	// ------------------------------------------------------------
	// image and datapath sizes
	// ------------------------------------------------------------
	localparam int IMG_W      = 8;
	localparam int CHAN_MAX   = 32;
	localparam int PIX_W      = 8;
	localparam int OUT_W      = 14;
	localparam int ADDR_W     = 11;
	localparam int MEM_DEPTH  = 2048;
	localparam int ORIGIN_MAX = 6;
	localparam int DEPTH_MIN  = 8;
	localparam int HAAR_CHANS = 4;

	// derived field widths of the address {channel, y, x}
	localparam int COORD_W = $clog2(IMG_W);
	localparam int CHAN_W  = $clog2(CHAN_MAX);

	// ------------------------------------------------------------
	// command opcodes and controller states
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		OP_LOAD     = 4'd0,
		OP_RIGHT    = 4'd1,
		OP_LEFT     = 4'd2,
		OP_UP       = 4'd3,
		OP_DOWN     = 4'd4,
		OP_DEPTH_DN = 4'd5,
		OP_DEPTH_UP = 4'd6,
		OP_DISPLAY  = 4'd7,
		OP_CONV     = 4'd8,
		OP_MEDIAN   = 4'd9,
		OP_HAAR     = 4'd10
	} op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ADJUST,
		ST_DISPLAY,
		ST_HAAR
	} state_e;

	typedef struct packed {
		logic              en;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [PIX_W-1:0]  wdata;
	} mem_req_t;

	typedef struct packed {
		logic             valid;
		logic [PIX_W-1:0] data;
	} pix_t;

	typedef struct packed {
		logic             valid;
		logic [OUT_W-1:0] data;
	} coef_t;

endpackage
